// ==== verilog.f ====
+incdir+test
verilog/pdp_pkg.sv
verilog/pdp_cfg_regs.sv
verilog/pdp_skid_buf.sv
verilog/pdp_lane_reduce.sv
verilog/pdp_med2d_core.sv
verilog/pdp_med2d_top.sv
test/pdp_clk_gen.sv
test/tb_pdp_med2d.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the med2d pooling testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_pdp_med2d -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1

// ==== test/tb_pdp_model.svh ====
// clamp to the signed range of a lane
function automatic int sat_lane(input int v, input int bits);
  int hi;
  int lo;
  hi = (1 << (bits - 1)) - 1;
  lo = -(1 << (bits - 1));
  if (v > hi) return hi;
  if (v < lo) return lo;
  return v;
endfunction

// 2'b00 falls through to max
function automatic int lane_op(input logic [1:0] op, input int x, input int z, input int bits);
  case (op)
    2'b01: return (x < z) ? x : z;
    2'b10: return sat_lane(x + z, bits);
    default: return (x > z) ? x : z;
  endcase
endfunction

function automatic logic [EW-1:0] elem_model(input logic prec, input logic [1:0] op,
                                             input logic [EW-1:0] a, input logic [EW-1:0] b);
  logic [EW-1:0] y;
  int lo;
  int hi;
  y = '0;
  if (prec == pdp_pkg::PREC_INT16) begin
    lo = lane_op(op, int'($signed(a[15:0])), int'($signed(b[15:0])), 16);
    y[15:0] = lo[15:0];
  end else begin
    lo = lane_op(op, int'($signed(a[7:0])), int'($signed(b[7:0])), 8);
    hi = lane_op(op, int'($signed(a[15:8])), int'($signed(b[15:8])), 8);
    y[15:0] = {hi[7:0], lo[7:0]};
  end
  y[21:20] = a[21:20] & b[21:20];
  return y;
endfunction

function automatic logic [ROW_W-1:0] row_model(input logic prec, input logic [1:0] op,
                                               input logic [ROW_W-1:0] a,
                                               input logic [ROW_W-1:0] b);
  logic [ROW_W-1:0] y;
  for (int e = 0; e < ROW_W / EW; e++) begin
    y[e*EW +: EW] = elem_model(prec, op, a[e*EW +: EW], b[e*EW +: EW]);
  end
  return y;
endfunction

function automatic logic [ROW_W-1:0] mask_model(input logic [ROW_W-1:0] row,
                                                input logic [NUM_CORES-1:0] en);
  logic [ROW_W-1:0] y;
  y = row;
  for (int c = 0; c < NUM_CORES; c++) begin
    if (!en[c]) y[c*pdp_pkg::CORE_W +: pdp_pkg::CORE_W] = '0;
  end
  return y;
endfunction

// ==== test/tb_pdp_med2d.sv ====
`timescale 1ns/1ps

module tb_pdp_med2d;

  localparam int NUM_CORES = 4;
  localparam int EW        = pdp_pkg::ELEM_W;
  localparam int ROW_W     = NUM_CORES * pdp_pkg::CORE_W;

  localparam logic       INT8    = pdp_pkg::PREC_INT8;
  localparam logic       INT16   = pdp_pkg::PREC_INT16;
  localparam logic [1:0] OP_RSVD = pdp_pkg::POOL_RSVD;
  localparam logic [1:0] OP_MIN  = pdp_pkg::POOL_MIN;
  localparam logic [1:0] OP_SUM  = pdp_pkg::POOL_SUM;
  localparam logic [1:0] OP_MAX  = pdp_pkg::POOL_MAX;

  typedef struct packed {
    bit         cfg;
    logic       prec;
    logic [1:0] pool;
    logic [2:0] kw;
    logic [2:0] kh;
    logic [7:0] en;
    int         wins;
    bit         bp;
    bit         big;
    bit         lock;
  } test_t;

  logic             clk;
  logic             rst;
  logic             cfg_we;
  logic [1:0]       cfg_addr;
  logic [7:0]       cfg_wdata;
  logic             in_valid;
  logic             in_ready;
  logic [ROW_W-1:0] in_data0;
  logic [ROW_W-1:0] in_data1;
  logic             out_valid;
  logic             out_ready;
  logic [ROW_W-1:0] out_data;

  test_t            tests [$];
  string            names [$];
  logic [ROW_W-1:0] exp_q [$];
  string            name_q [$];
  logic [31:0]      drv_lfsr;
  logic [31:0]      rdy_lfsr;
  logic             next_ready;
  bit               bp_on;
  int               total_beats;
  int               cycles;
  int               limit;

  `include "tb_pdp_model.svh"

  pdp_clk_gen #(.PERIOD_NS(4)) u_clk (.clk(clk));

  pdp_med2d_top #(.NUM_CORES(NUM_CORES)) dut (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data0  (in_data0),
    .in_data1  (in_data1),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], st[0]};
      st = st[0] ? ((st >> 1) ^ 32'h80200003) : (st >> 1);
    end
    return r;
  endfunction

  // big puts every value near a signed 16-bit limit
  function automatic logic [ROW_W-1:0] make_row(input bit big);
    logic [ROW_W-1:0] r;
    logic [31:0]      v;
    logic [31:0]      p;
    for (int e = 0; e < ROW_W / EW; e++) begin
      v = take_bits(drv_lfsr, 16);
      p = take_bits(drv_lfsr, 8);
      if (big) v[15:12] = {v[15], {3{~v[15]}}};
      r[e*EW +: EW] = {p[7:2], p[1:0], 4'b0000, v[15:0]};
    end
    return r;
  endfunction

  function automatic void add_test(input string name, input test_t tc);
    names.push_back(name);
    tests.push_back(tc);
    total_beats += tc.wins * (tc.kw + 1) * (tc.kh + 1);
  endfunction

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [ROW_W-1:0] exp,
                             input logic [ROW_W-1:0] act);
    if (act !== exp) begin
      $display("Error: test %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
    cfg_addr  = addr;
    cfg_wdata = data;
    cfg_we    = 1'b1;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic send_beat(input logic [ROW_W-1:0] d0, input logic [ROW_W-1:0] d1);
    logic done;
    done     = 1'b0;
    in_data0 = d0;
    in_data1 = d1;
    in_valid = 1'b1;
    while (!done) begin
      done = in_ready;
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic run_test(input int t);
    test_t            tc;
    logic [ROW_W-1:0] d0;
    logic [ROW_W-1:0] d1;
    logic [ROW_W-1:0] row;
    logic [ROW_W-1:0] acc;
    int               nbeats;
    tc     = tests[t];
    nbeats = (tc.kw + 1) * (tc.kh + 1);
    // settings change only with the core idle
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    if (tc.cfg) begin
      cfg_write(pdp_pkg::REG_PREC, {7'd0, tc.prec});
      cfg_write(pdp_pkg::REG_POOL, {6'd0, tc.pool});
      cfg_write(pdp_pkg::REG_KERNEL, {2'd0, tc.kh, tc.kw});
      cfg_write(pdp_pkg::REG_CORE_EN, tc.en);
    end
    bp_on = tc.bp;
    for (int w = 0; w < tc.wins; w++) begin
      for (int b = 0; b < nbeats; b++) begin
        d0  = make_row(tc.big);
        d1  = make_row(tc.big);
        row = row_model(tc.prec, tc.pool, d0, d1);
        acc = (b == 0) ? row : row_model(tc.prec, tc.pool, acc, row);
        if (tc.bp && take_bits(drv_lfsr, 2) == 0) begin
          @(posedge clk);
          #1;
        end
        send_beat(d0, d1);
        // mid-window write, must be dropped
        if (tc.lock && b == 2) cfg_write(pdp_pkg::REG_POOL, {6'd0, OP_MIN});
      end
      exp_q.push_back(mask_model(acc, tc.en[NUM_CORES-1:0]));
      name_q.push_back(names[t]);
    end
  endtask

  always @(posedge clk) begin
    next_ready = !bp_on || (take_bits(rdy_lfsr, 2) != 0);
    #1;
    out_ready = next_ready;
  end

  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("output beat arrived with no window left to expect");
        abort_run();
      end else begin
        check_value(name_q.pop_front(), exp_q.pop_front(), out_data);
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("timeout after %0d cycles with %0d results missing", cycles, exp_q.size());
      abort_run();
    end
  end

  initial begin
    rst         = 1'b1;
    cfg_we      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    in_valid    = 1'b0;
    in_data0    = '0;
    in_data1    = '0;
    out_ready   = 1'b0;
    bp_on       = 1'b0;
    drv_lfsr    = 32'h129b;
    rdy_lfsr    = 32'h129b;
    total_beats = 0;
    cycles      = 0;
    // cfg, prec, pool, kw, kh, core_en, windows, back-pressure, big values, lockout
    add_test("reset_max", '{0, INT16, OP_MAX, 0, 0, 8'hff, 4, 0, 0, 0});
    add_test("int8_max", '{1, INT8, OP_MAX, 0, 0, 8'hff, 4, 0, 0, 0});
    add_test("int8_sum_2x2", '{1, INT8, OP_SUM, 1, 1, 8'hff, 3, 0, 0, 0});
    add_test("int16_min_2x2", '{1, INT16, OP_MIN, 1, 1, 8'hff, 3, 0, 0, 0});
    add_test("int16_max_2x2", '{1, INT16, OP_MAX, 1, 1, 8'hff, 3, 0, 0, 0});
    add_test("int16_sum_sat", '{1, INT16, OP_SUM, 1, 1, 8'hff, 3, 0, 1, 0});
    add_test("core_en_mask", '{1, INT16, OP_MAX, 1, 0, 8'h05, 3, 0, 0, 0});
    add_test("bp_int8_sum", '{1, INT8, OP_SUM, 0, 0, 8'h0b, 12, 1, 0, 0});
    add_test("bp_rsvd_2x2", '{1, INT16, OP_RSVD, 1, 1, 8'hff, 4, 1, 0, 0});
    add_test("lock_mid", '{1, INT16, OP_MAX, 1, 1, 8'hff, 2, 0, 0, 1});
    add_test("lock_idle", '{1, INT16, OP_MIN, 1, 1, 8'hff, 2, 0, 0, 0});
    limit = total_beats * 4 + 100;

    repeat (4) begin
      @(posedge clk);
      #1;
      check_value("reset_out_valid", '0, out_valid);
    end
    rst = 1'b0;
    check_value("reset_in_ready", 1, in_ready);

    for (int t = 0; t < tests.size(); t++) begin
      run_test(t);
    end
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (8) @(posedge clk);

    if (out_valid === 1'b0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("extra output beat after the last window");
      abort_run();
    end
  end

endmodule

// ==== test/pdp_clk_gen.sv ====
`timescale 1ns/1ps

module pdp_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// ==== verilog/pdp_med2d_top.sv ====
`timescale 1ns/1ps

module pdp_med2d_top #(
  parameter int NUM_CORES = 8
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   cfg_we,
  input  logic [pdp_pkg::CFG_ADDR_W-1:0]         cfg_addr,
  input  logic [pdp_pkg::CFG_DATA_W-1:0]         cfg_wdata,
  input  logic                                   in_valid,
  output logic                                   in_ready,
  input  logic [NUM_CORES*pdp_pkg::CORE_W-1:0]   in_data0,
  input  logic [NUM_CORES*pdp_pkg::CORE_W-1:0]   in_data1,
  output logic                                   out_valid,
  input  logic                                   out_ready,
  output logic [NUM_CORES*pdp_pkg::CORE_W-1:0]   out_data
);

  localparam int ROW_W = NUM_CORES * pdp_pkg::CORE_W;

  pdp_pkg::prec_e                        prec;
  pdp_pkg::pool_e                        pool_op;
  logic [pdp_pkg::KERNEL_FIELD_W-1:0]    kernel_w;
  logic [pdp_pkg::KERNEL_FIELD_W-1:0]    kernel_h;
  logic [NUM_CORES-1:0]                  core_en;
  logic                                  busy;
  logic                                  core_valid;
  logic                                  core_ready;
  logic [2*ROW_W-1:0]                    core_pair;
  logic                                  res_valid;
  logic                                  res_ready;
  logic [ROW_W-1:0]                      res_data;

  pdp_cfg_regs #(.NUM_CORES(NUM_CORES)) u_cfg (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .busy      (busy),
    .prec      (prec),
    .pool_op   (pool_op),
    .kernel_w  (kernel_w),
    .kernel_h  (kernel_h),
    .core_en   (core_en)
  );

  // both rows travel together, data1 in the upper half
  pdp_skid_buf #(.payload_t(logic [2*ROW_W-1:0])) u_in_buf (
    .clk     (clk),
    .rst     (rst),
    .s_valid (in_valid),
    .s_ready (in_ready),
    .s_data  ({in_data1, in_data0}),
    .m_valid (core_valid),
    .m_ready (core_ready),
    .m_data  (core_pair)
  );

  pdp_med2d_core #(.NUM_CORES(NUM_CORES)) u_core (
    .clk       (clk),
    .rst       (rst),
    .prec      (prec),
    .pool_op   (pool_op),
    .kernel_w  (kernel_w),
    .kernel_h  (kernel_h),
    .core_en   (core_en),
    .in_valid  (core_valid),
    .in_ready  (core_ready),
    .data0     (core_pair[ROW_W-1:0]),
    .data1     (core_pair[2*ROW_W-1:ROW_W]),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .busy      (busy)
  );

  pdp_skid_buf #(.payload_t(logic [ROW_W-1:0])) u_out_buf (
    .clk     (clk),
    .rst     (rst),
    .s_valid (res_valid),
    .s_ready (res_ready),
    .s_data  (res_data),
    .m_valid (out_valid),
    .m_ready (out_ready),
    .m_data  (out_data)
  );

endmodule

// ==== verilog/pdp_med2d_core.sv ====
`timescale 1ns/1ps

module pdp_med2d_core #(
  parameter int NUM_CORES = 8
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  pdp_pkg::prec_e                         prec,
  input  pdp_pkg::pool_e                         pool_op,
  input  logic [pdp_pkg::KERNEL_FIELD_W-1:0]     kernel_w,
  input  logic [pdp_pkg::KERNEL_FIELD_W-1:0]     kernel_h,
  input  logic [NUM_CORES-1:0]                   core_en,
  input  logic                                   in_valid,
  output logic                                   in_ready,
  input  logic [NUM_CORES*pdp_pkg::CORE_W-1:0]   data0,
  input  logic [NUM_CORES*pdp_pkg::CORE_W-1:0]   data1,
  output logic                                   res_valid,
  input  logic                                   res_ready,
  output logic [NUM_CORES*pdp_pkg::CORE_W-1:0]   res_data,
  output logic                                   busy
);

  localparam int EW        = pdp_pkg::ELEM_W;
  localparam int CW        = pdp_pkg::CORE_W;
  localparam int ROW_W     = NUM_CORES * CW;
  localparam int NUM_ELEMS = NUM_CORES * pdp_pkg::ELEMS_PER_CORE;

  logic [ROW_W-1:0]                      row_res;
  logic [ROW_W-1:0]                      acc_red;
  logic [ROW_W-1:0]                      acc;
  logic [pdp_pkg::KERNEL_FIELD_W-1:0]    col_cnt;
  logic [pdp_pkg::KERNEL_FIELD_W-1:0]    row_cnt;
  logic                                  accept;
  logic                                  first_beat;
  logic                                  last_col;
  logic                                  last_beat;

  // per element: rows first, then into the running window value
  for (genvar e = 0; e < NUM_ELEMS; e++) begin : g_elem
    pdp_lane_reduce u_row (
      .prec    (prec),
      .pool_op (pool_op),
      .a       (data0[e*EW +: EW]),
      .b       (data1[e*EW +: EW]),
      .y       (row_res[e*EW +: EW])
    );

    pdp_lane_reduce u_acc (
      .prec    (prec),
      .pool_op (pool_op),
      .a       (acc[e*EW +: EW]),
      .b       (row_res[e*EW +: EW]),
      .y       (acc_red[e*EW +: EW])
    );
  end

  for (genvar c = 0; c < NUM_CORES; c++) begin : g_mask
    assign res_data[c*CW +: CW] = core_en[c] ? acc[c*CW +: CW] : '0;
  end

  // the accumulator must hold while a result waits
  assign in_ready   = !res_valid;
  assign accept     = in_valid && in_ready;
  assign first_beat = (col_cnt == '0) && (row_cnt == '0);
  assign last_col   = (col_cnt == kernel_w);
  assign last_beat  = last_col && (row_cnt == kernel_h);
  assign busy       = !first_beat || res_valid;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      col_cnt   <= '0;
      row_cnt   <= '0;
      res_valid <= 1'b0;
    end else begin
      if (res_valid && res_ready) begin
        res_valid <= 1'b0;
      end
      if (accept) begin
        if (last_beat) begin
          col_cnt   <= '0;
          row_cnt   <= '0;
          res_valid <= 1'b1;
        end else if (last_col) begin
          col_cnt <= '0;
          row_cnt <= row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      acc <= first_beat ? row_res : acc_red;
    end
  end

endmodule

// ==== verilog/pdp_lane_reduce.sv ====
`timescale 1ns/1ps

module pdp_lane_reduce (
  input  pdp_pkg::prec_e                prec,
  input  pdp_pkg::pool_e                pool_op,
  input  logic [pdp_pkg::ELEM_W-1:0]    a,
  input  logic [pdp_pkg::ELEM_W-1:0]    b,
  output logic [pdp_pkg::ELEM_W-1:0]    y
);

  localparam int DW = pdp_pkg::DATA_W;
  localparam int FL = pdp_pkg::FLAG_LO;
  localparam int FW = pdp_pkg::FLAG_W;

  function automatic logic [15:0] op16(input pdp_pkg::pool_e op, input logic [15:0] x,
                                       input logic [15:0] z);
    logic [16:0] s;
    logic        gt;
    s  = {x[15], x} + {z[15], z};
    gt = $signed(x) > $signed(z);
    case (op)
      pdp_pkg::POOL_MIN: op16 = gt ? z : x;
      // overflow when the two top bits of the extended sum disagree
      pdp_pkg::POOL_SUM: op16 = (s[16] != s[15]) ? {s[16], {15{~s[16]}}} : s[15:0];
      pdp_pkg::POOL_MAX, pdp_pkg::POOL_RSVD: op16 = gt ? x : z;
    endcase
  endfunction

  function automatic logic [7:0] op8(input pdp_pkg::pool_e op, input logic [7:0] x,
                                     input logic [7:0] z);
    logic [8:0] s;
    logic       gt;
    s  = {x[7], x} + {z[7], z};
    gt = $signed(x) > $signed(z);
    case (op)
      pdp_pkg::POOL_MIN: op8 = gt ? z : x;
      pdp_pkg::POOL_SUM: op8 = (s[8] != s[7]) ? {s[8], {7{~s[8]}}} : s[7:0];
      pdp_pkg::POOL_MAX, pdp_pkg::POOL_RSVD: op8 = gt ? x : z;
    endcase
  endfunction

  logic [DW-1:0] v16;
  logic [DW-1:0] v8;

  assign v16 = op16(pool_op, a[DW-1:0], b[DW-1:0]);
  // byte lanes never interact, including saturation
  assign v8  = {op8(pool_op, a[15:8], b[15:8]), op8(pool_op, a[7:0], b[7:0])};

  always_comb begin
    y = '0;
    y[DW-1:0] = (prec == pdp_pkg::PREC_INT16) ? v16 : v8;
    y[FL +: FW] = a[FL +: FW] & b[FL +: FW];
  end

endmodule

// ==== verilog/pdp_skid_buf.sv ====
`timescale 1ns/1ps

module pdp_skid_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     s_valid,
  output logic     s_ready,
  input  payload_t s_data,
  output logic     m_valid,
  input  logic     m_ready,
  output payload_t m_data
);

  payload_t   mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  // ready only depends on local state, so it never chains through
  assign s_ready = (count != 2'd2);
  assign m_valid = (count != 2'd0);
  assign m_data  = mem[rd_ptr];

  assign push = s_valid && s_ready;
  assign pop  = m_valid && m_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= s_data;
    end
  end

endmodule

// ==== verilog/pdp_cfg_regs.sv ====
`timescale 1ns/1ps

module pdp_cfg_regs #(
  parameter int NUM_CORES = 8
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  cfg_we,
  input  logic [pdp_pkg::CFG_ADDR_W-1:0]        cfg_addr,
  input  logic [pdp_pkg::CFG_DATA_W-1:0]        cfg_wdata,
  input  logic                                  busy,
  output pdp_pkg::prec_e                        prec,
  output pdp_pkg::pool_e                        pool_op,
  output logic [pdp_pkg::KERNEL_FIELD_W-1:0]    kernel_w,
  output logic [pdp_pkg::KERNEL_FIELD_W-1:0]    kernel_h,
  output logic [NUM_CORES-1:0]                  core_en
);

  localparam int KW = pdp_pkg::KERNEL_FIELD_W;

  logic wr_ok;

  // a window in flight keeps the settings it started with
  assign wr_ok = cfg_we && !busy;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prec     <= pdp_pkg::PREC_INT16;
      pool_op  <= pdp_pkg::POOL_MAX;
      kernel_w <= '0;
      kernel_h <= '0;
      core_en  <= '1;
    end else if (wr_ok) begin
      case (cfg_addr)
        pdp_pkg::REG_PREC: begin
          prec <= pdp_pkg::prec_e'(cfg_wdata[0]);
        end
        pdp_pkg::REG_POOL: begin
          pool_op <= pdp_pkg::pool_e'(cfg_wdata[1:0]);
        end
        pdp_pkg::REG_KERNEL: begin
          kernel_w <= cfg_wdata[KW-1:0];
          kernel_h <= cfg_wdata[2*KW-1:KW];
        end
        pdp_pkg::REG_CORE_EN: begin
          core_en <= NUM_CORES'(cfg_wdata);
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== verilog/pdp_pkg.sv ====
package pdp_pkg;

  // element layout inside a 112-bit core slice
  localparam int ELEM_W         = 28;
  localparam int DATA_W         = 16;
  localparam int FLAG_LO        = 20;
  localparam int FLAG_W         = 2;
  localparam int ELEMS_PER_CORE = 4;
  localparam int CORE_W         = ELEMS_PER_CORE * ELEM_W;

  // int8 packs two signed byte lanes into the 16-bit value field
  typedef enum logic {
    PREC_INT8  = 1'b0,
    PREC_INT16 = 1'b1
  } prec_e;

  // 2'b00 is not a distinct op, the datapath handles it as max
  typedef enum logic [1:0] {
    POOL_RSVD = 2'b00,
    POOL_MIN  = 2'b01,
    POOL_SUM  = 2'b10,
    POOL_MAX  = 2'b11
  } pool_e;

  // config port geometry
  localparam int CFG_ADDR_W = 2;
  localparam int CFG_DATA_W = 8;

  // register map
  localparam logic [CFG_ADDR_W-1:0] REG_PREC    = 2'd0;
  localparam logic [CFG_ADDR_W-1:0] REG_POOL    = 2'd1;
  localparam logic [CFG_ADDR_W-1:0] REG_KERNEL  = 2'd2;
  localparam logic [CFG_ADDR_W-1:0] REG_CORE_EN = 2'd3;

  // kernel_w in bits 2:0, kernel_h in bits 5:3 of REG_KERNEL
  localparam int KERNEL_FIELD_W = 3;

endpackage
